//--- verilog/rv_pkg.sv
package rv_pkg;

	// Major opcodes handled by this slice
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLT    = 4'd5,
		ALU_SLTU   = 4'd6,
		ALU_SLL    = 4'd7,
		ALU_SRL    = 4'd8,
		ALU_SRA    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_e;

	// Zero must stay NONE, a cleared pipeline register is a bubble
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LT   = 3'd3,
		BR_GE   = 3'd4,
		BR_LTU  = 3'd5,
		BR_GEU  = 3'd6,
		BR_JUMP = 3'd7
	} br_op_e;

	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_PC4 = 2'd1,
		WB_IMM = 2'd2
	} wb_sel_e;

	typedef enum logic [2:0] {
		IMM_I = 3'd0,
		IMM_S = 3'd1,
		IMM_B = 3'd2,
		IMM_U = 3'd3,
		IMM_J = 3'd4
	} imm_sel_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	// Store and branch layout, immediate split around the register fields
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} inst_s_t;

	typedef union packed {
		inst_r_t r;
		inst_s_t s;
	} inst_u;

endpackage

//--- verilog/reg_file.sv
`timescale 1ns/100ps

module reg_file #(
	parameter int NREGS = 32
) (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic [4:0]  rs1_i,
	input  logic [4:0]  rs2_i,
	input  logic [4:0]  rd_i,
	input  logic        we_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata1_o,
	output logic [31:0] rdata2_o
);

	localparam int IDX_W = $clog2(NREGS);

	logic [31:0] regs [NREGS];

	// x0 and out-of-range indices read zero, a same-cycle write passes through
	function automatic logic [31:0] read_port(input logic [4:0] idx);
		logic [31:0] val;
		val = '0;
		if (idx != 5'd0 && idx < NREGS) begin
			if (we_i && rd_i == idx)
				val = wdata_i;
			else
				val = regs[idx[IDX_W-1:0]];
		end
		return val;
	endfunction

	always_comb begin
		rdata1_o = read_port(rs1_i);
		rdata2_o = read_port(rs2_i);
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end else if (we_i && rd_i != 5'd0 && rd_i < NREGS) begin
			regs[rd_i[IDX_W-1:0]] <= wdata_i;
		end
	end

endmodule

//--- verilog/imm_gen.sv
`timescale 1ns/100ps

module imm_gen (
	input  rv_pkg::inst_u    inst_i,
	input  rv_pkg::imm_sel_e imm_sel_i,
	output logic [31:0]      imm_o
);

	import rv_pkg::*;

	logic [31:0] w;

	assign w = inst_i;

	always_comb begin
		case (imm_sel_i)
			IMM_I: imm_o = {{20{inst_i.r.funct7[6]}}, inst_i.r.funct7, inst_i.r.rs2};
			IMM_S: imm_o = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
			IMM_B: begin
				imm_o = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_lo[0],
					inst_i.s.imm_hi[5:0], inst_i.s.imm_lo[4:1], 1'b0};
			end
			IMM_U: imm_o = {w[31:12], 12'b0};
			// J format scrambles bits 20..1 across the upper word
			IMM_J: imm_o = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			default: imm_o = '0;
		endcase
	end

endmodule

//--- verilog/ctrl_decode.sv
`timescale 1ns/100ps

module ctrl_decode (
	input  rv_pkg::inst_u    inst_i,
	output rv_pkg::alu_op_e  alu_op_o,
	output logic             a_sel_o,
	output logic             b_sel_o,
	output rv_pkg::imm_sel_e imm_sel_o,
	output rv_pkg::br_op_e   br_op_o,
	output rv_pkg::wb_sel_e  wb_sel_o,
	output logic             reg_we_o
);

	import rv_pkg::*;

	// Shared by OP and OP-IMM, SUB only exists in the register form
	function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt,
		input logic is_reg);
		alu_op_e op;
		case (f3)
			3'b000: begin
				if (is_reg && alt)
					op = ALU_SUB;
				else
					op = ALU_ADD;
			end
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: begin
				if (alt)
					op = ALU_SRA;
				else
					op = ALU_SRL;
			end
			3'b110: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		alu_op_o  = ALU_ADD;
		a_sel_o   = 1'b0;
		b_sel_o   = 1'b0;
		imm_sel_o = IMM_I;
		br_op_o   = BR_NONE;
		wb_sel_o  = WB_ALU;
		reg_we_o  = 1'b0;
		case (inst_i.r.opcode)
			OPC_OP: begin
				alu_op_o = alu_from_funct(inst_i.r.funct3, inst_i.r.funct7[5], 1'b1);
				reg_we_o = 1'b1;
			end
			OPC_OP_IMM: begin
				alu_op_o = alu_from_funct(inst_i.r.funct3, inst_i.r.funct7[5], 1'b0);
				b_sel_o  = 1'b1;
				reg_we_o = 1'b1;
			end
			OPC_LUI: begin
				alu_op_o  = ALU_PASS_B;
				b_sel_o   = 1'b1;
				imm_sel_o = IMM_U;
				wb_sel_o  = WB_IMM;
				reg_we_o  = 1'b1;
			end
			OPC_AUIPC: begin
				a_sel_o   = 1'b1;
				b_sel_o   = 1'b1;
				imm_sel_o = IMM_U;
				reg_we_o  = 1'b1;
			end
			OPC_JAL: begin
				a_sel_o   = 1'b1;
				b_sel_o   = 1'b1;
				imm_sel_o = IMM_J;
				br_op_o   = BR_JUMP;
				wb_sel_o  = WB_PC4;
				reg_we_o  = 1'b1;
			end
			OPC_JALR: begin
				b_sel_o  = 1'b1;
				br_op_o  = BR_JUMP;
				wb_sel_o = WB_PC4;
				reg_we_o = 1'b1;
			end
			OPC_BRANCH: begin
				imm_sel_o = IMM_B;
				case (inst_i.r.funct3)
					3'b000: br_op_o = BR_EQ;
					3'b001: br_op_o = BR_NE;
					3'b100: br_op_o = BR_LT;
					3'b101: br_op_o = BR_GE;
					3'b110: br_op_o = BR_LTU;
					3'b111: br_op_o = BR_GEU;
					default: br_op_o = BR_NONE;
				endcase
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/id_stage.sv
`timescale 1ns/100ps

module id_stage #(
	parameter int NREGS = 32
) (
	input  logic             clk_i,
	input  logic             reset_i,
	input  logic             enable_i,
	input  logic             flush_i,
	input  rv_pkg::inst_u    inst_i,
	input  logic [31:0]      pc_i,
	input  logic             wb_we_i,
	input  logic [4:0]       wb_rd_i,
	input  logic [31:0]      wb_data_i,
	output logic [31:0]      rs1_o,
	output logic [31:0]      rs2_o,
	output logic [31:0]      imm_o,
	output logic [31:0]      pc_o,
	output logic [31:0]      pc4_o,
	output rv_pkg::alu_op_e  alu_op_o,
	output logic             a_sel_o,
	output logic             b_sel_o,
	output rv_pkg::br_op_e   br_op_o,
	output rv_pkg::wb_sel_e  wb_sel_o,
	output logic [4:0]       rd_o,
	output logic             reg_we_o
);

	import rv_pkg::*;

	logic [31:0] rs1_w;
	logic [31:0] rs2_w;
	logic [31:0] imm_w;
	logic [31:0] pc4_w;
	alu_op_e     alu_op_w;
	logic        a_sel_w;
	logic        b_sel_w;
	imm_sel_e    imm_sel_w;
	br_op_e      br_op_w;
	wb_sel_e     wb_sel_w;
	logic        reg_we_w;

	// Write only commits while the pipe advances
	reg_file #(.NREGS(NREGS)) u_reg_file (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.rs1_i    (inst_i.r.rs1),
		.rs2_i    (inst_i.r.rs2),
		.rd_i     (wb_rd_i),
		.we_i     (wb_we_i & enable_i),
		.wdata_i  (wb_data_i),
		.rdata1_o (rs1_w),
		.rdata2_o (rs2_w)
	);

	imm_gen u_imm_gen (
		.inst_i    (inst_i),
		.imm_sel_i (imm_sel_w),
		.imm_o     (imm_w)
	);

	ctrl_decode u_ctrl_decode (
		.inst_i    (inst_i),
		.alu_op_o  (alu_op_w),
		.a_sel_o   (a_sel_w),
		.b_sel_o   (b_sel_w),
		.imm_sel_o (imm_sel_w),
		.br_op_o   (br_op_w),
		.wb_sel_o  (wb_sel_w),
		.reg_we_o  (reg_we_w)
	);

	assign pc4_w = pc_i + 32'd4;

	// Reset and flush both leave a bubble
	always_ff @(posedge clk_i) begin
		if (reset_i || (enable_i && flush_i)) begin
			rs1_o    <= '0;
			rs2_o    <= '0;
			imm_o    <= '0;
			pc_o     <= '0;
			pc4_o    <= '0;
			alu_op_o <= ALU_ADD;
			a_sel_o  <= 1'b0;
			b_sel_o  <= 1'b0;
			br_op_o  <= BR_NONE;
			wb_sel_o <= WB_ALU;
			rd_o     <= '0;
			reg_we_o <= 1'b0;
		end else if (enable_i) begin
			rs1_o    <= rs1_w;
			rs2_o    <= rs2_w;
			imm_o    <= imm_w;
			pc_o     <= pc_i;
			pc4_o    <= pc4_w;
			alu_op_o <= alu_op_w;
			a_sel_o  <= a_sel_w;
			b_sel_o  <= b_sel_w;
			br_op_o  <= br_op_w;
			wb_sel_o <= wb_sel_w;
			rd_o     <= inst_i.r.rd;
			reg_we_o <= reg_we_w;
		end
	end

endmodule

//--- verilog/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
	input  logic            clk_i,
	input  logic            reset_i,
	input  logic            enable_i,
	input  logic [31:0]     rs1_i,
	input  logic [31:0]     rs2_i,
	input  logic [31:0]     imm_i,
	input  logic [31:0]     pc_i,
	input  logic [31:0]     pc4_i,
	input  rv_pkg::alu_op_e alu_op_i,
	input  logic            a_sel_i,
	input  logic            b_sel_i,
	input  rv_pkg::br_op_e  br_op_i,
	input  rv_pkg::wb_sel_e wb_sel_i,
	input  logic [4:0]      rd_i,
	input  logic            reg_we_i,
	output logic            br_taken_o,
	output logic [31:0]     br_target_o,
	output logic [31:0]     alu_o,
	output logic [31:0]     pc4_o,
	output logic [31:0]     imm_o,
	output rv_pkg::wb_sel_e wb_sel_o,
	output logic [4:0]      rd_o,
	output logic            reg_we_o
);

	import rv_pkg::*;

	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] alu_res;

	assign op_a = a_sel_i ? pc_i : rs1_i;
	assign op_b = b_sel_i ? imm_i : rs2_i;

	always_comb begin
		case (alu_op_i)
			ALU_ADD:    alu_res = op_a + op_b;
			ALU_SUB:    alu_res = op_a - op_b;
			ALU_AND:    alu_res = op_a & op_b;
			ALU_OR:     alu_res = op_a | op_b;
			ALU_XOR:    alu_res = op_a ^ op_b;
			ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
			// Only the low five bits count as shift amount
			ALU_SLL:    alu_res = op_a << op_b[4:0];
			ALU_SRL:    alu_res = op_a >> op_b[4:0];
			ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = '0;
		endcase
	end

	always_comb begin
		case (br_op_i)
			BR_EQ:   br_taken_o = (rs1_i == rs2_i);
			BR_NE:   br_taken_o = (rs1_i != rs2_i);
			BR_LT:   br_taken_o = ($signed(rs1_i) < $signed(rs2_i));
			BR_GE:   br_taken_o = ($signed(rs1_i) >= $signed(rs2_i));
			BR_LTU:  br_taken_o = (rs1_i < rs2_i);
			BR_GEU:  br_taken_o = (rs1_i >= rs2_i);
			BR_JUMP: br_taken_o = 1'b1;
			default: br_taken_o = 1'b0;
		endcase
	end

	// JALR is the jump that takes rs1 as base
	assign br_target_o = (br_op_i == BR_JUMP && !a_sel_i) ? {alu_res[31:1], 1'b0}
		: pc_i + imm_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			alu_o    <= '0;
			pc4_o    <= '0;
			imm_o    <= '0;
			wb_sel_o <= WB_ALU;
			rd_o     <= '0;
			reg_we_o <= 1'b0;
		end else if (enable_i) begin
			alu_o    <= alu_res;
			pc4_o    <= pc4_i;
			imm_o    <= imm_i;
			wb_sel_o <= wb_sel_i;
			rd_o     <= rd_i;
			reg_we_o <= reg_we_i;
		end
	end

endmodule

//--- verilog/wb_select.sv
`timescale 1ns/100ps

module wb_select (
	input  logic [31:0]     alu_i,
	input  logic [31:0]     pc4_i,
	input  logic [31:0]     imm_i,
	input  rv_pkg::wb_sel_e wb_sel_i,
	input  logic [4:0]      rd_i,
	input  logic            reg_we_i,
	output logic            wb_we_o,
	output logic [4:0]      wb_rd_o,
	output logic [31:0]     wb_data_o
);

	import rv_pkg::*;

	always_comb begin
		case (wb_sel_i)
			WB_PC4:  wb_data_o = pc4_i;
			WB_IMM:  wb_data_o = imm_i;
			default: wb_data_o = alu_i;
		endcase
	end

	// x0 writes never leave the core
	assign wb_we_o = reg_we_i && (rd_i != 5'd0);
	assign wb_rd_o = rd_i;

endmodule

//--- verilog/int_core.sv
`timescale 1ns/100ps

module int_core #(
	parameter int NREGS = 32
) (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic [31:0] inst_i,
	input  logic [31:0] pc_i,
	input  logic        enable_i,
	input  logic        flush_i,
	output logic        wb_we_o,
	output logic [4:0]  wb_rd_o,
	output logic [31:0] wb_data_o,
	output logic        br_taken_o,
	output logic [31:0] br_target_o
);

	import rv_pkg::*;

	logic [31:0] id_rs1;
	logic [31:0] id_rs2;
	logic [31:0] id_imm;
	logic [31:0] id_pc;
	logic [31:0] id_pc4;
	alu_op_e     id_alu_op;
	logic        id_a_sel;
	logic        id_b_sel;
	br_op_e      id_br_op;
	wb_sel_e     id_wb_sel;
	logic [4:0]  id_rd;
	logic        id_reg_we;

	logic [31:0] ex_alu;
	logic [31:0] ex_pc4;
	logic [31:0] ex_imm;
	wb_sel_e     ex_wb_sel;
	logic [4:0]  ex_rd;
	logic        ex_reg_we;

	id_stage #(.NREGS(NREGS)) u_id_stage (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.enable_i  (enable_i),
		.flush_i   (flush_i),
		.inst_i    (inst_i),
		.pc_i      (pc_i),
		.wb_we_i   (wb_we_o),
		.wb_rd_i   (wb_rd_o),
		.wb_data_i (wb_data_o),
		.rs1_o     (id_rs1),
		.rs2_o     (id_rs2),
		.imm_o     (id_imm),
		.pc_o      (id_pc),
		.pc4_o     (id_pc4),
		.alu_op_o  (id_alu_op),
		.a_sel_o   (id_a_sel),
		.b_sel_o   (id_b_sel),
		.br_op_o   (id_br_op),
		.wb_sel_o  (id_wb_sel),
		.rd_o      (id_rd),
		.reg_we_o  (id_reg_we)
	);

	ex_stage u_ex_stage (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.enable_i    (enable_i),
		.rs1_i       (id_rs1),
		.rs2_i       (id_rs2),
		.imm_i       (id_imm),
		.pc_i        (id_pc),
		.pc4_i       (id_pc4),
		.alu_op_i    (id_alu_op),
		.a_sel_i     (id_a_sel),
		.b_sel_i     (id_b_sel),
		.br_op_i     (id_br_op),
		.wb_sel_i    (id_wb_sel),
		.rd_i        (id_rd),
		.reg_we_i    (id_reg_we),
		.br_taken_o  (br_taken_o),
		.br_target_o (br_target_o),
		.alu_o       (ex_alu),
		.pc4_o       (ex_pc4),
		.imm_o       (ex_imm),
		.wb_sel_o    (ex_wb_sel),
		.rd_o        (ex_rd),
		.reg_we_o    (ex_reg_we)
	);

	wb_select u_wb_select (
		.alu_i     (ex_alu),
		.pc4_i     (ex_pc4),
		.imm_i     (ex_imm),
		.wb_sel_i  (ex_wb_sel),
		.rd_i      (ex_rd),
		.reg_we_i  (ex_reg_we),
		.wb_we_o   (wb_we_o),
		.wb_rd_o   (wb_rd_o),
		.wb_data_o (wb_data_o)
	);

endmodule

//--- sim/int_core_chk.sv
`timescale 1ns/100ps

module int_core_chk (
	input logic        clk_i,
	input logic        reset_i,
	input logic        enable_i,
	input logic        flush_i,
	input logic        wb_we_i,
	input logic [4:0]  wb_rd_i,
	input logic [31:0] wb_data_i,
	input logic        br_taken_i,
	input logic [31:0] br_target_i
);

	int fails = 0;

	// x0 writes are masked before the outputs
	no_x0_write: assert property (@(posedge clk_i) disable iff (reset_i)
		wb_we_i |-> wb_rd_i != 5'd0)
	else begin
		$error("write-back strobe raised for register x0");
		fails++;
	end

	outputs_known: assert property (@(posedge clk_i) disable iff (reset_i)
		!$isunknown({wb_we_i, wb_rd_i, wb_data_i, br_taken_i, br_target_i}))
	else begin
		$error("unknown value on a core output");
		fails++;
	end

	// A flushed slot leaves a bubble in decode
	flush_no_branch: assert property (@(posedge clk_i) disable iff (reset_i)
		enable_i && flush_i |=> !br_taken_i)
	else begin
		$error("branch taken right after a flushed slot");
		fails++;
	end

endmodule

bind int_core int_core_chk u_chk (
	.clk_i       (clk_i),
	.reset_i     (reset_i),
	.enable_i    (enable_i),
	.flush_i     (flush_i),
	.wb_we_i     (wb_we_o),
	.wb_rd_i     (wb_rd_o),
	.wb_data_i   (wb_data_o),
	.br_taken_i  (br_taken_o),
	.br_target_i (br_target_o)
);

//--- sim/int_core_tb.sv
`timescale 1ns/100ps

module int_core_tb;

	import rv_pkg::*;

	localparam logic [31:0] NOP = 32'h0000_0013;
	localparam int IMM_ROUNDS = 4;
	localparam int REG_ROUNDS = 4;
	localparam int BR_PAIRS = 4;
	localparam int JUMP_ROUNDS = 2;
	// Clock edges per test including the three drain slots of each
	localparam int TOTAL_SLOTS = 8 + (IMM_ROUNDS * 22 + 3) + (REG_ROUNDS * 38 + 3)
		+ (BR_PAIRS * 20 + 3) + (JUMP_ROUNDS * 10 + 3) + 16 + 11;
	localparam int WATCHDOG_NS = (TOTAL_SLOTS + 50) * 8;

	logic        clk_i;
	logic        reset_i;
	logic [31:0] inst_i;
	logic [31:0] pc_i;
	logic        enable_i;
	logic        flush_i;
	logic        wb_we_o;
	logic [4:0]  wb_rd_o;
	logic [31:0] wb_data_o;
	logic        br_taken_o;
	logic [31:0] br_target_o;

	int          seed;
	int          errors;
	int          tests_ok;
	int          tests_bad;
	int          slot_idx;
	logic [31:0] pc_cnt;
	logic [31:0] ref_regs [32];
	logic [4:0]  exp_rd [$];
	logic [31:0] exp_data [$];
	int          exp_slot [$];
	// Branch expectation of the driven slot and of the decode register
	logic        slot_check;
	logic        slot_taken;
	logic [31:0] slot_target;
	logic        dec_check;
	logic        dec_taken;
	logic [31:0] dec_target;

	int_core #(.NREGS(32)) DUT (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.enable_i    (enable_i),
		.flush_i     (flush_i),
		.wb_we_o     (wb_we_o),
		.wb_rd_o     (wb_rd_o),
		.wb_data_o   (wb_data_o),
		.br_taken_o  (br_taken_o),
		.br_target_o (br_target_o)
	);

	always #4 clk_i = ~clk_i;

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
		input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	// RV32I integer semantics with the shift amount taken from the low five bits
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'b000: r = alt ? a - b : a + b;
			3'b001: r = a << b[4:0];
			3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: r = (a < b) ? 32'd1 : 32'd0;
			3'b100: r = a ^ b;
			3'b101: r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic ref_exec(input logic [31:0] inst, input logic [31:0] pc, output logic we,
		output logic [31:0] val, output logic is_br, output logic taken,
		output logic [31:0] tgt);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [2:0]  f3;
		a = ref_regs[inst[19:15]];
		b = ref_regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		f3 = inst[14:12];
		we = 1'b1;
		val = '0;
		is_br = 1'b0;
		taken = 1'b0;
		tgt = '0;
		case (inst[6:0])
			OPC_OP: val = alu_ref(f3, inst[30], a, b);
			OPC_OP_IMM: val = alu_ref(f3, inst[30] && f3 == 3'b101, a, imm_i);
			OPC_LUI: val = {inst[31:12], 12'b0};
			OPC_AUIPC: val = pc + {inst[31:12], 12'b0};
			OPC_JAL: begin
				val = pc + 32'd4;
				is_br = 1'b1;
				taken = 1'b1;
				tgt = pc + imm_j;
			end
			OPC_JALR: begin
				val = pc + 32'd4;
				is_br = 1'b1;
				taken = 1'b1;
				tgt = (a + imm_i) & ~32'd1;
			end
			OPC_BRANCH: begin
				we = 1'b0;
				is_br = 1'b1;
				tgt = pc + imm_b;
				case (f3)
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					3'b101: taken = ($signed(a) >= $signed(b));
					3'b110: taken = (a < b);
					default: taken = (a >= b);
				endcase
			end
			default: we = 1'b0;
		endcase
		we = we && inst[11:7] != 5'd0;
	endtask

	// One fetch slot with the pipe enabled
	task automatic issue(input logic [31:0] inst, input logic flush);
		logic        we;
		logic [31:0] val;
		logic        is_br;
		logic        taken;
		logic [31:0] tgt;
		@(posedge clk_i);
		#1;
		inst_i = inst;
		pc_i = pc_cnt;
		enable_i = 1'b1;
		flush_i = flush;
		slot_idx++;
		ref_exec(inst, pc_cnt, we, val, is_br, taken, tgt);
		if (flush) begin
			is_br = 1'b0;
			taken = 1'b0;
		end else if (we) begin
			ref_regs[inst[11:7]] = val;
			exp_rd.push_back(inst[11:7]);
			exp_data.push_back(val);
			exp_slot.push_back(slot_idx);
		end
		slot_check = is_br;
		slot_taken = taken;
		slot_target = tgt;
		pc_cnt = pc_cnt + 32'd4;
	endtask

	task automatic issue_spaced(input logic [31:0] inst);
		issue(inst, 1'b0);
		issue(NOP, 1'b0);
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [31:0] val);
		logic [31:0] upper;
		upper = val + 32'h800;
		issue_spaced(u_type(upper[31:12], rd, OPC_LUI));
		issue_spaced(i_type(val[11:0], rd, 3'b000, rd, OPC_OP_IMM));
	endtask

	task automatic stall_for(input int n);
		logic [70:0] held;
		@(posedge clk_i);
		#1;
		enable_i = 1'b0;
		flush_i = 1'b1;
		inst_i = j_type(21'h000100, 5'd24);
		pc_i = 32'hdead_0000;
		held = {wb_we_o, wb_rd_o, wb_data_o, br_taken_o, br_target_o};
		repeat (n) begin
			@(posedge clk_i);
			#1;
			if ({wb_we_o, wb_rd_o, wb_data_o, br_taken_o, br_target_o} !== held) begin
				$display("** Error at %0t: outputs changed while enable_i was low", $time);
				errors++;
			end
		end
		flush_i = 1'b0;
	endtask

	task automatic finish_test(input string name, input int err_before);
		repeat (3) issue(NOP, 1'b0);
		if (errors == err_before) begin
			$display("%s: passed", name);
			tests_ok++;
		end else begin
			$display("%s: failed with %0d errors", name, errors - err_before);
			tests_bad++;
		end
	endtask

	task automatic imm_arith_ops();
		logic [31:0] rnd;
		logic [11:0] imm;
		logic [2:0]  f3;
		for (int r = 0; r < IMM_ROUNDS; r++) begin
			load_reg(5'd5, $random(seed));
			for (int i = 0; i < 9; i++) begin
				rnd = $random(seed);
				f3 = (i < 8) ? 3'(i) : 3'b101;
				imm = rnd[11:0];
				if (f3 == 3'b001 || f3 == 3'b101)
					imm = {(i == 8) ? 7'h20 : 7'h00, (r == 0) ? 5'd31 : rnd[4:0]};
				issue_spaced(i_type(imm, 5'd5, f3, 5'd6 + 5'(i), OPC_OP_IMM));
			end
		end
	endtask

	task automatic reg_arith_ops();
		logic [31:0] a;
		logic [31:0] b;
		logic [2:0]  f3;
		logic [6:0]  f7;
		for (int r = 0; r < REG_ROUNDS; r++) begin
			a = $random(seed);
			b = $random(seed);
			case (r)
				0: b = 32'd31;
				1: b = 32'd32 + (b & 32'd31);
				2: begin
					a = a | 32'h8000_0000;
					b = b & 32'h7fff_ffff;
				end
				default: ;
			endcase
			load_reg(5'd16, a);
			load_reg(5'd17, b);
			for (int i = 0; i < 10; i++) begin
				f3 = (i < 8) ? 3'(i) : ((i == 8) ? 3'b000 : 3'b101);
				f7 = (i < 8) ? 7'h00 : 7'h20;
				issue_spaced(r_type(f7, 5'd17, 5'd16, f3, 5'd18 + 5'(i), OPC_OP));
				issue(NOP, 1'b0);
			end
		end
	endtask

	task automatic branch_conditions();
		logic [31:0] a;
		logic [31:0] b;
		logic [12:0] off;
		logic [2:0]  f3;
		for (int p = 0; p < BR_PAIRS; p++) begin
			a = $random(seed);
			b = $random(seed);
			case (p)
				0: b = a;
				1: begin
					a = a | 32'h8000_0000;
					b = b & 32'h7fff_ffff;
				end
				2: begin
					a = a & 32'h7fff_ffff;
					b = b | 32'h8000_0000;
				end
				default: begin
					a = a & 32'h00ff_ffff;
					b = a + 32'd9;
				end
			endcase
			load_reg(5'd28, a);
			load_reg(5'd29, b);
			for (int i = 0; i < 6; i++) begin
				off = $random(seed);
				off[0] = 1'b0;
				f3 = (i < 2) ? 3'(i) : 3'(i + 2);
				issue_spaced(b_type(off, 5'd29, 5'd28, f3));
			end
		end
	endtask

	task automatic jump_and_pc();
		logic [31:0] rnd;
		for (int r = 0; r < JUMP_ROUNDS; r++) begin
			// Odd base with an even offset gives an odd JALR sum
			load_reg(5'd7, $random(seed) | 32'd1);
			rnd = $random(seed);
			issue_spaced(j_type({rnd[20:1], 1'b0}, 5'd1));
			rnd = $random(seed);
			issue_spaced(i_type({rnd[11:1], 1'b0}, 5'd7, 3'b000, 5'd2, OPC_JALR));
			rnd = $random(seed);
			issue_spaced(u_type(rnd[19:0], 5'd3, OPC_AUIPC));
		end
	endtask

	task automatic stall_and_flush();
		issue(i_type(12'h3a5, 5'd0, 3'b000, 5'd20, OPC_OP_IMM), 1'b0);
		issue(b_type(13'h0040, 5'd0, 5'd0, 3'b000), 1'b0);
		stall_for(4);
		issue(i_type(12'h055, 5'd0, 3'b000, 5'd21, OPC_OP_IMM), 1'b1);
		issue(j_type(21'h000800, 5'd22), 1'b1);
		issue(NOP, 1'b0);
		issue(NOP, 1'b0);
		issue_spaced(r_type(7'h00, 5'd22, 5'd21, 3'b000, 5'd23, OPC_OP));
	endtask

	task automatic zero_register();
		issue_spaced(i_type(12'h7ff, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
		issue_spaced(u_type(20'habcde, 5'd0, OPC_LUI));
		issue_spaced(r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd25, OPC_OP));
		issue_spaced(i_type(12'hfff, 5'd0, 3'b000, 5'd26, OPC_OP_IMM));
	endtask

	always @(posedge clk_i) begin
		if (reset_i) begin
			dec_check <= 1'b0;
			dec_taken <= 1'b0;
			dec_target <= '0;
		end else if (enable_i) begin
			dec_check <= slot_check;
			dec_taken <= slot_taken;
			dec_target <= slot_target;
		end
	end

	// Write-back commits at the next rising edge when enable_i is high
	always @(negedge clk_i) begin : wb_monitor
		logic [4:0]  rd;
		logic [31:0] data;
		int          slot;
		if (!reset_i) begin
			if (br_taken_o !== dec_taken) begin
				$display("** Error at %0t: br_taken_o is %b, expected %b", $time,
					br_taken_o, dec_taken);
				errors++;
			end
			if (dec_check && br_target_o !== dec_target) begin
				$display("** Error at %0t: br_target_o is %h, expected %h", $time,
					br_target_o, dec_target);
				errors++;
			end
			if (enable_i && wb_we_o === 1'b1) begin
				if (exp_rd.size() == 0) begin
					$display("Unexpected write to x%0d at %0t with nothing pending",
						wb_rd_o, $time);
					errors++;
				end else begin
					rd = exp_rd.pop_front();
					data = exp_data.pop_front();
					slot = exp_slot.pop_front();
					if (wb_rd_o !== rd || wb_data_o !== data) begin
						$display("** Error at %0t: write x%0d = %h, expected x%0d = %h",
							$time, wb_rd_o, wb_data_o, rd, data);
						errors++;
					end
					if (slot + 2 != slot_idx) begin
						$display("Write to x%0d came %0d slots after issue instead of 2",
							rd, slot_idx - slot);
						errors++;
					end
				end
			end else if (enable_i && exp_slot.size() > 0 && exp_slot[0] + 2 <= slot_idx) begin
				$display("Write to x%0d did not appear at %0t", exp_rd[0], $time);
				errors++;
				rd = exp_rd.pop_front();
				data = exp_data.pop_front();
				slot = exp_slot.pop_front();
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		int err_before;
		clk_i = 1'b0;
		reset_i = 1'b1;
		inst_i = NOP;
		pc_i = '0;
		enable_i = 1'b0;
		flush_i = 1'b0;
		seed = 28404;
		errors = 0;
		tests_ok = 0;
		tests_bad = 0;
		slot_idx = 0;
		pc_cnt = 32'h0000_1000;
		slot_check = 1'b0;
		slot_taken = 1'b0;
		slot_target = '0;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;
		repeat (8) @(posedge clk_i);
		#1;
		reset_i = 1'b0;

		err_before = errors;
		imm_arith_ops();
		finish_test("immediate arithmetic", err_before);
		err_before = errors;
		reg_arith_ops();
		finish_test("register arithmetic", err_before);
		err_before = errors;
		branch_conditions();
		finish_test("branches", err_before);
		err_before = errors;
		jump_and_pc();
		finish_test("jumps and pc", err_before);
		err_before = errors;
		stall_and_flush();
		finish_test("stall and flush", err_before);
		err_before = errors;
		zero_register();
		finish_test("register zero", err_before);

		if (exp_rd.size() != 0) begin
			$display("%0d expected writes never reached the outputs", exp_rd.size());
			errors++;
		end
		errors = errors + DUT.u_chk.fails;
		$display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- sources.f
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/imm_gen.sv
verilog/ctrl_decode.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/wb_select.sv
verilog/int_core.sv
sim/int_core_chk.sv
sim/int_core_tb.sv
